/* rtl/gmem_pkg.sv */
`default_nettype none

package gmem_pkg;

   localparam int DATA_W       = 32;
   localparam int BE_W         = DATA_W / 8;
   localparam int LINE_WORDS   = 4;
   localparam int LINE_WORDS_W = 2;
   localparam int LINE_ADDR_W  = 6;
   localparam int WORD_ADDR_W  = LINE_ADDR_W + LINE_WORDS_W;
   localparam int LINE_BE_W    = LINE_WORDS * BE_W;
   localparam int N_LINES      = 2 ** LINE_ADDR_W;
   localparam int N_RCV        = 4;
   localparam int N_RCV_W      = 2;
   localparam int RCV_HALF     = N_RCV / 2;
   localparam int PRI_W        = 3;
   localparam int PRI_CLASS_W  = 2;

   typedef logic [LINE_WORDS*DATA_W-1:0] line_t;

   typedef struct packed {
      logic                   rnw;
      logic [BE_W-1:0]        be;
      logic [WORD_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]      wdata;
   } cu_req_t;

   typedef struct packed {
      logic [LINE_ADDR_W-1:0] line_addr;
      line_t                  data;
   } rd_resp_t;

   typedef struct packed {
      logic [WORD_ADDR_W-1:0] addr;
      logic [BE_W-1:0]        be;
      logic [DATA_W-1:0]      wdata;
      logic [PRI_W-1:0]       pri;
   } rcv_entry_t;

   typedef enum logic [2:0] {
      idle,
      read_line,
      req_write,
      wait_merge,
      write_line
   } rcv_state_e;

   typedef struct packed {
      logic [LINE_ADDR_W-1:0] line_addr;
      logic [LINE_BE_W-1:0]   be;
      line_t                  data;
   } line_wr_t;

   typedef struct packed {
      logic               found;
      logic [N_RCV_W-1:0] idx;
   } pick_t;

   // highest priority class first, highest index inside a class
   function automatic pick_t pick_rcv(input logic [N_RCV-1:0] want,
                                      input rcv_entry_t [N_RCV-1:0] ent);
      pick_t                  p;
      logic [PRI_CLASS_W-1:0] best;
      p    = '0;
      best = '0;
      for (int i = 0; i < N_RCV; i++) begin
         if (want[i] && (!p.found || ent[i].pri[PRI_W-1 -: PRI_CLASS_W] >= best)) begin
            p.found = 1'b1;
            p.idx   = N_RCV_W'(i);
            best    = ent[i].pri[PRI_W-1 -: PRI_CLASS_W];
         end
      end
      return p;
   endfunction

endpackage

`default_nettype wire

/* rtl/cu_intake.sv */
`default_nettype none

module cu_intake import gmem_pkg::*; (
   input  wire logic             clk,
   input  wire logic             nrst,
   input  wire logic             cu_req_i,
   input  wire cu_req_t          cu_req_data_i,
   output logic                  cu_ack_o,
   input  wire logic [N_RCV-1:0] rcv_idle_i,
   output logic      [N_RCV-1:0] rcv_go_o,
   output cu_req_t               req_held_o
);

   logic             req_q;
   cu_req_t          data_q;
   logic             ack_q;
   logic             half_q;
   logic [N_RCV-1:0] go_n;
   logic             dispatch;

   // lowest idle receiver in the current half
   always_comb begin
      go_n = '0;
      for (int j = RCV_HALF - 1; j >= 0; j--) begin
         if (rcv_idle_i[int'(half_q) * RCV_HALF + j]) begin
            go_n = '0;
            go_n[int'(half_q) * RCV_HALF + j] = 1'b1;
         end
      end
   end

   assign dispatch = req_q && !ack_q && (|go_n);

   always_ff @(posedge clk) begin
      if (nrst) begin
         req_q    <= 1'b0;
         ack_q    <= 1'b0;
         half_q   <= 1'b0;
         rcv_go_o <= '0;
      end else begin
         req_q    <= cu_req_i;
         half_q   <= ~half_q;
         rcv_go_o <= '0;
         if (ack_q) begin
            // release phase
            if (!cu_req_i) begin
               ack_q <= 1'b0;
            end
         end else if (dispatch) begin
            rcv_go_o <= go_n;
            ack_q    <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      data_q <= cu_req_data_i;
      if (dispatch) begin
         req_held_o <= data_q;
      end
   end

   assign cu_ack_o = ack_q;

endmodule

`default_nettype wire

/* rtl/receiver_pool.sv */
`default_nettype none

module receiver_pool import gmem_pkg::*; (
   input  wire logic             clk,
   input  wire logic             nrst,
   input  wire logic [N_RCV-1:0] rcv_go_i,
   input  wire cu_req_t          req_held_i,
   input  wire logic [N_RCV-1:0] in_pipe_i,
   input  wire logic [N_RCV-1:0] will_write_i,
   input  wire logic [N_RCV-1:0] will_write_d_i,
   input  wire logic [N_RCV-1:0] rd_issued_i,
   input  wire logic             wr_commit_i,
   output logic      [N_RCV-1:0] rcv_idle_o,
   output rcv_entry_t [N_RCV-1:0] rcv_entry_o,
   output logic      [N_RCV-1:0] want_read_o,
   output logic      [N_RCV-1:0] want_write_o,
   output logic      [N_RCV-1:0] pend_data_o,
   output logic                  idle_o
);

   rcv_state_e               state [N_RCV];
   rcv_entry_t [N_RCV-1:0]   entry;

   always_ff @(posedge clk) begin
      if (nrst) begin
         for (int i = 0; i < N_RCV; i++) begin
            state[i] <= idle;
         end
      end else begin
         for (int i = 0; i < N_RCV; i++) begin
            case (state[i])
               idle: begin
                  if (rcv_go_i[i]) begin
                     state[i] <= req_held_i.rnw ? read_line : req_write;
                  end
               end
               read_line: begin
                  if (rd_issued_i[i]) begin
                     state[i] <= idle;
                  end
               end
               req_write: begin
                  // merged into another line before its own turn
                  if (will_write_i[i]) begin
                     state[i] <= write_line;
                  end else if (in_pipe_i[i]) begin
                     state[i] <= wait_merge;
                  end
               end
               wait_merge: begin
                  if (will_write_i[i]) begin
                     state[i] <= write_line;
                  end
               end
               write_line: begin
                  // wait until no later line in the pipe still holds our bytes
                  if (wr_commit_i && !will_write_d_i[i]) begin
                     state[i] <= idle;
                  end
               end
               default: begin
                  state[i] <= idle;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < N_RCV; i++) begin
         if (state[i] == idle && rcv_go_i[i]) begin
            entry[i].addr  <= req_held_i.addr;
            entry[i].be    <= req_held_i.be;
            entry[i].wdata <= req_held_i.wdata;
            entry[i].pri   <= '0;
         end else if ((state[i] == read_line || state[i] == req_write) &&
                      entry[i].pri != '1) begin
            // aging while waiting for the port or the pipe
            entry[i].pri <= entry[i].pri + 1'b1;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < N_RCV; i++) begin
         rcv_idle_o[i]   = (state[i] == idle);
         want_read_o[i]  = (state[i] == read_line);
         want_write_o[i] = (state[i] == req_write);
         pend_data_o[i]  = (state[i] == req_write) || (state[i] == wait_merge);
      end
   end

   assign rcv_entry_o = entry;

   // a dispatch in flight is not idle yet
   assign idle_o = (&rcv_idle_o) && !(|rcv_go_i);

endmodule

`default_nettype wire

/* rtl/write_merge.sv */
`default_nettype none

module write_merge import gmem_pkg::*; (
   input  wire logic             clk,
   input  wire logic             nrst,
   input  wire rcv_entry_t [N_RCV-1:0] rcv_entry_i,
   input  wire logic [N_RCV-1:0] want_write_i,
   input  wire logic [N_RCV-1:0] pend_data_i,
   input  wire logic             wr_stall_i,
   output logic      [N_RCV-1:0] in_pipe_o,
   output logic      [N_RCV-1:0] will_write_o,
   output logic      [N_RCV-1:0] will_write_d_o,
   output line_wr_t              wr_line_o,
   output logic                  wr_valid_o
);

   logic [3:0]                          v_q;
   logic [3:0]                          ld;
   pick_t                               wr_pick;
   logic [N_RCV_W-1:0]                  s0_idx;
   logic [LINE_ADDR_W-1:0]              s0_line;
   logic [LINE_ADDR_W-1:0]              s1_line;
   logic [LINE_ADDR_W-1:0]              s2_line;
   logic [N_RCV-1:0]                    match_n;
   logic [N_RCV-1:0]                    match_q;
   logic [LINE_BE_W-1:0][N_RCV_W-1:0]   own_n;
   logic [LINE_BE_W-1:0][N_RCV_W-1:0]   own_q;
   logic [LINE_BE_W-1:0]                be_n;
   logic [LINE_BE_W-1:0]                be_q;
   logic [N_RCV-1:0]                    ww_n;
   logic [N_RCV-1:0]                    ww_q;
   logic [N_RCV-1:0]                    ww_d_q;
   line_wr_t                            wr_line_q;

   // a stage moves when the stall is off or some later stage is empty
   always_comb begin
      ld[3] = !wr_stall_i;
      ld[2] = ld[3] || !v_q[2];
      ld[1] = ld[2] || !v_q[1];
      ld[0] = ld[1] || !v_q[0];
   end

   // stage 0: writer select
   always_comb begin
      wr_pick   = pick_rcv(want_write_i, rcv_entry_i);
      in_pipe_o = '0;
      if (wr_pick.found && ld[0]) begin
         in_pipe_o[wr_pick.idx] = 1'b1;
      end
   end

   // stage 1: receivers with pending data to the same line
   always_comb begin
      s0_line = rcv_entry_i[s0_idx].addr[WORD_ADDR_W-1 -: LINE_ADDR_W];
      for (int i = 0; i < N_RCV; i++) begin
         match_n[i] = v_q[0] && pend_data_i[i] &&
                      (rcv_entry_i[i].addr[WORD_ADDR_W-1 -: LINE_ADDR_W] == s0_line);
      end
   end

   // stage 2: byte owners, highest index wins a shared byte
   always_comb begin
      own_n = '0;
      be_n  = '0;
      ww_n  = '0;
      if (v_q[1]) begin
         for (int j = 0; j < LINE_WORDS; j++) begin
            for (int k = 0; k < BE_W; k++) begin
               for (int i = 0; i < N_RCV; i++) begin
                  if (match_q[i] && pend_data_i[i] && rcv_entry_i[i].be[k] &&
                      rcv_entry_i[i].addr[WORD_ADDR_W-1 -: LINE_ADDR_W] == s1_line &&
                      rcv_entry_i[i].addr[LINE_WORDS_W-1:0] == LINE_WORDS_W'(j)) begin
                     own_n[j*BE_W+k] = N_RCV_W'(i);
                     be_n[j*BE_W+k]  = 1'b1;
                     ww_n[i]         = 1'b1;
                  end
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         v_q    <= '0;
         ww_q   <= '0;
         ww_d_q <= '0;
      end else begin
         if (ld[0]) begin
            v_q[0] <= wr_pick.found;
         end
         if (ld[1]) begin
            v_q[1] <= v_q[0];
         end
         if (ld[2]) begin
            v_q[2] <= v_q[1];
            ww_q   <= ww_n;
         end
         if (ld[3]) begin
            v_q[3] <= v_q[2];
            ww_d_q <= ww_q;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ld[0]) begin
         s0_idx <= wr_pick.idx;
      end
      if (ld[1]) begin
         s1_line <= s0_line;
         match_q <= match_n;
      end
      if (ld[2]) begin
         s2_line <= s1_line;
         own_q   <= own_n;
         be_q    <= be_n;
      end
      // stage 3: line data and byte enables
      if (ld[3]) begin
         wr_line_q.line_addr <= s2_line;
         wr_line_q.be        <= be_q;
         for (int j = 0; j < LINE_WORDS; j++) begin
            for (int k = 0; k < BE_W; k++) begin
               wr_line_q.data[(j*BE_W+k)*8 +: 8] <=
                  rcv_entry_i[own_q[j*BE_W+k]].wdata[k*8 +: 8];
            end
         end
      end
   end

   assign will_write_o   = ww_q;
   assign will_write_d_o = ww_d_q;
   assign wr_line_o      = wr_line_q;
   assign wr_valid_o     = v_q[3];

endmodule

`default_nettype wire

/* rtl/port_arbiter.sv */
`default_nettype none

module port_arbiter import gmem_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   nrst,
   input  wire rcv_entry_t [N_RCV-1:0] rcv_entry_i,
   input  wire logic [N_RCV-1:0]       want_read_i,
   input  wire line_wr_t               wr_line_i,
   input  wire logic                   wr_valid_i,
   input  wire line_t                  ram_rdata_i,
   output logic [LINE_ADDR_W-1:0]      ram_addr_o,
   output logic [LINE_BE_W-1:0]        ram_we_o,
   output line_t                       ram_wdata_o,
   output logic [N_RCV-1:0]            rd_issued_o,
   output logic                        wr_commit_o,
   output logic                        wr_stall_o,
   output logic                        rd_ack_o,
   output rd_resp_t                    rd_resp_o
);

   pick_t                  rd_pick;
   logic [N_RCV-1:0]       last_rd_q;
   logic                   wr_go;
   logic                   rd_v_q;
   logic                   rd_ack_q;
   logic                   wr_commit_q;
   logic [LINE_BE_W-1:0]   ram_we_q;
   logic [LINE_ADDR_W-1:0] ram_addr_q;
   line_t                  ram_wdata_q;
   logic [LINE_ADDR_W-1:0] resp_line_q;

   always_comb begin
      rd_pick     = pick_rcv(want_read_i & ~last_rd_q, rcv_entry_i);
      rd_issued_o = '0;
      if (rd_pick.found) begin
         rd_issued_o[rd_pick.idx] = 1'b1;
      end
   end

   // reads own the port, the write pipe waits
   assign wr_go      = wr_valid_i && !rd_pick.found;
   assign wr_stall_o = wr_valid_i && rd_pick.found;

   always_ff @(posedge clk) begin
      if (nrst) begin
         last_rd_q   <= '0;
         rd_v_q      <= 1'b0;
         rd_ack_q    <= 1'b0;
         wr_commit_q <= 1'b0;
         ram_we_q    <= '0;
      end else begin
         last_rd_q   <= rd_issued_o;
         rd_v_q      <= rd_pick.found;
         rd_ack_q    <= rd_v_q;
         wr_commit_q <= wr_go;
         ram_we_q    <= wr_go ? wr_line_i.be : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_pick.found) begin
         ram_addr_q <= rcv_entry_i[rd_pick.idx].addr[WORD_ADDR_W-1 -: LINE_ADDR_W];
      end else begin
         ram_addr_q <= wr_line_i.line_addr;
      end
      ram_wdata_q <= wr_line_i.data;
      // line address follows the ram read latency
      resp_line_q <= ram_addr_q;
   end

   assign ram_addr_o  = ram_addr_q;
   assign ram_we_o    = ram_we_q;
   assign ram_wdata_o = ram_wdata_q;
   assign wr_commit_o = wr_commit_q;
   assign rd_ack_o    = rd_ack_q;

   always_comb begin
      rd_resp_o.line_addr = resp_line_q;
      rd_resp_o.data      = ram_rdata_i;
   end

endmodule

`default_nettype wire

/* rtl/line_ram.sv */
`default_nettype none

module line_ram import gmem_pkg::*; (
   input  wire logic                   clk,
   input  wire logic [LINE_ADDR_W-1:0] addr_i,
   input  wire logic [LINE_BE_W-1:0]   we_i,
   input  wire line_t                  wdata_i,
   output line_t                       rdata_o
);

   line_t mem [N_LINES];

   initial begin
      for (int i = 0; i < N_LINES; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < LINE_BE_W; b++) begin
         if (we_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
         end
      end
      // old data on a same-cycle write
      rdata_o <= mem[addr_i];
   end

endmodule

`default_nettype wire

/* rtl/gmem_ctrl.sv */
`default_nettype none

module gmem_ctrl import gmem_pkg::*; (
   input  wire logic    clk,
   input  wire logic    nrst,
   input  wire logic    cu_req_i,
   input  wire cu_req_t cu_req_data_i,
   output logic         cu_ack_o,
   output logic         rd_ack_o,
   output rd_resp_t     rd_resp_o,
   output logic         idle_o
);

   logic [N_RCV-1:0]       rcv_go;
   cu_req_t                req_held;
   logic [N_RCV-1:0]       rcv_idle;
   rcv_entry_t [N_RCV-1:0] rcv_entry;
   logic [N_RCV-1:0]       want_read;
   logic [N_RCV-1:0]       want_write;
   logic [N_RCV-1:0]       pend_data;
   logic [N_RCV-1:0]       in_pipe;
   logic [N_RCV-1:0]       will_write;
   logic [N_RCV-1:0]       will_write_d;
   logic [N_RCV-1:0]       rd_issued;
   logic                   wr_commit;
   line_wr_t               wr_line;
   logic                   wr_valid;
   logic                   wr_stall;
   logic [LINE_ADDR_W-1:0] ram_addr;
   logic [LINE_BE_W-1:0]   ram_we;
   line_t                  ram_wdata;
   line_t                  ram_rdata;

   cu_intake u_intake (
      .clk(clk), .nrst(nrst),
      .cu_req_i(cu_req_i), .cu_req_data_i(cu_req_data_i), .cu_ack_o(cu_ack_o),
      .rcv_idle_i(rcv_idle), .rcv_go_o(rcv_go), .req_held_o(req_held)
   );

   receiver_pool u_pool (
      .clk(clk), .nrst(nrst),
      .rcv_go_i(rcv_go), .req_held_i(req_held),
      .in_pipe_i(in_pipe), .will_write_i(will_write), .will_write_d_i(will_write_d),
      .rd_issued_i(rd_issued), .wr_commit_i(wr_commit),
      .rcv_idle_o(rcv_idle), .rcv_entry_o(rcv_entry),
      .want_read_o(want_read), .want_write_o(want_write), .pend_data_o(pend_data),
      .idle_o(idle_o)
   );

   write_merge u_merge (
      .clk(clk), .nrst(nrst),
      .rcv_entry_i(rcv_entry), .want_write_i(want_write), .pend_data_i(pend_data),
      .wr_stall_i(wr_stall),
      .in_pipe_o(in_pipe), .will_write_o(will_write), .will_write_d_o(will_write_d),
      .wr_line_o(wr_line), .wr_valid_o(wr_valid)
   );

   port_arbiter u_arb (
      .clk(clk), .nrst(nrst),
      .rcv_entry_i(rcv_entry), .want_read_i(want_read),
      .wr_line_i(wr_line), .wr_valid_i(wr_valid), .ram_rdata_i(ram_rdata),
      .ram_addr_o(ram_addr), .ram_we_o(ram_we), .ram_wdata_o(ram_wdata),
      .rd_issued_o(rd_issued), .wr_commit_o(wr_commit), .wr_stall_o(wr_stall),
      .rd_ack_o(rd_ack_o), .rd_resp_o(rd_resp_o)
   );

   line_ram u_ram (
      .clk(clk),
      .addr_i(ram_addr), .we_i(ram_we), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
   );

endmodule

`default_nettype wire

/* testbench/gmem_ctrl_tb.sv */
`default_nettype none

module gmem_ctrl_tb import gmem_pkg::*; ();

   localparam int TIMEOUT = 200;

   logic     clk;
   logic     nrst;
   logic     cu_req_i;
   cu_req_t  cu_req_data_i;
   logic     cu_ack_o;
   logic     rd_ack_o;
   rd_resp_t rd_resp_o;
   logic     idle_o;

   logic [31:0]          seed;
   logic [7:0]           model [N_LINES][LINE_BE_W];
   logic [LINE_BE_W-1:0] dirty [N_LINES];
   int                   pend_rd [N_LINES];
   int                   rd_count;
   int                   resp_count;
   rd_resp_t             exp_resp;

   gmem_ctrl UUT (
      .clk(clk), .nrst(nrst),
      .cu_req_i(cu_req_i), .cu_req_data_i(cu_req_data_i), .cu_ack_o(cu_ack_o),
      .rd_ack_o(rd_ack_o), .rd_resp_o(rd_resp_o), .idle_o(idle_o)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // byte b of the model line sits at bits b*8
   function automatic line_t model_line(input int line);
      line_t d;
      for (int b = 0; b < LINE_BE_W; b++) begin
         d[b*8 +: 8] = model[line][b];
      end
      return d;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_resp(input string name, input rd_resp_t got, input rd_resp_t exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   // one four-phase transfer that scrambles its data after ack
   task automatic handshake(input cu_req_t req);
      int t;
      check_flag("cu_ack_o", cu_ack_o, 1'b0);
      cu_req_data_i = req;
      cu_req_i      = 1'b1;
      t = 0;
      do begin
         @(negedge clk);
         t++;
         if (t > TIMEOUT) begin
            abort_run("cu_ack_o never rose while cu_req_i was high");
         end
      end while (!cu_ack_o);
      if (t < 2) begin
         abort_run("cu_ack_o rose less than two cycles after cu_req_i");
      end
      cu_req_i = 1'b0;
      seed = lcg_step(seed);
      cu_req_data_i.wdata = seed;
      cu_req_data_i.addr  = seed[15:8];
      t = 0;
      do begin
         @(negedge clk);
         t++;
         if (t > TIMEOUT) begin
            abort_run("cu_ack_o stayed high after cu_req_i fell");
         end
      end while (cu_ack_o);
      if (t != 1) begin
         abort_run("cu_ack_o did not fall one cycle after cu_req_i fell");
      end
   endtask

   // all receivers idle and every read answered
   task automatic wait_idle();
      int t;
      t = 0;
      while (!(idle_o && resp_count == rd_count)) begin
         @(negedge clk);
         t++;
         if (t > TIMEOUT) begin
            abort_run("idle_o did not return high with all reads answered in time");
         end
         check_flag("cu_ack_o", cu_ack_o, 1'b0);
      end
      for (int i = 0; i < N_LINES; i++) begin
         dirty[i] = '0;
      end
   endtask

   task automatic write_word(input logic [WORD_ADDR_W-1:0] addr,
                             input logic [BE_W-1:0] be,
                             input logic [DATA_W-1:0] wdata);
      int                   line;
      int                   word;
      logic [LINE_BE_W-1:0] mask;
      cu_req_t              req;
      line = int'(addr[WORD_ADDR_W-1 -: LINE_ADDR_W]);
      word = int'(addr[LINE_WORDS_W-1:0]);
      mask = LINE_BE_W'(be) << (word * BE_W);
      // overlapping bytes must not race inside the merge
      if ((dirty[line] & mask) != '0) begin
         wait_idle();
      end
      dirty[line] = dirty[line] | mask;
      for (int k = 0; k < BE_W; k++) begin
         if (be[k]) begin
            model[line][word*BE_W+k] = wdata[k*8 +: 8];
         end
      end
      req.rnw   = 1'b0;
      req.be    = be;
      req.addr  = addr;
      req.wdata = wdata;
      handshake(req);
   endtask

   task automatic issue_read(input int line);
      cu_req_t req;
      seed      = lcg_step(seed);
      req.rnw   = 1'b1;
      req.be    = seed[3:0];
      req.addr  = {LINE_ADDR_W'(line), seed[5:4]};
      req.wdata = seed;
      pend_rd[line]++;
      rd_count++;
      handshake(req);
   endtask

   // read responses may come in any order
   always @(negedge clk) begin
      if (!nrst && rd_ack_o) begin
         if (pend_rd[int'(rd_resp_o.line_addr)] == 0) begin
            abort_run("read response for a line with no read pending");
         end
         exp_resp.line_addr = rd_resp_o.line_addr;
         exp_resp.data      = model_line(int'(rd_resp_o.line_addr));
         check_resp("rd_resp_o", rd_resp_o, exp_resp);
         pend_rd[int'(rd_resp_o.line_addr)]--;
         resp_count++;
      end
   end

   initial begin
      int                     line;
      logic [WORD_ADDR_W-1:0] addr;
      logic [BE_W-1:0]        be;
      clk           = 1'b0;
      nrst          = 1'b1;
      cu_req_i      = 1'b0;
      cu_req_data_i = '0;
      seed          = 32'he1591ad1;
      rd_count      = 0;
      resp_count    = 0;
      for (int i = 0; i < N_LINES; i++) begin
         dirty[i]   = '0;
         pend_rd[i] = 0;
         for (int b = 0; b < LINE_BE_W; b++) begin
            model[i][b] = 8'h00;
         end
      end
      repeat (2) @(negedge clk);
      nrst = 1'b0;
      check_flag("cu_ack_o", cu_ack_o, 1'b0);
      check_flag("rd_ack_o", rd_ack_o, 1'b0);
      check_flag("idle_o", idle_o, 1'b1);

      // random write bursts followed by random read bursts
      for (int r = 0; r < 6; r++) begin
         for (int i = 0; i < 16; i++) begin
            seed = lcg_step(seed);
            addr = seed[15:8];
            // even rounds crowd into lines 0 to 15
            if (r % 2 == 0) begin
               addr[7:6] = 2'b00;
            end
            be = seed[19:16];
            if (be == '0) begin
               be = 4'hf;
            end
            seed = lcg_step(seed);
            write_word(addr, be, seed);
         end
         wait_idle();
         for (int i = 0; i < 20; i++) begin
            seed = lcg_step(seed);
            line = int'(seed[13:8]);
            if (r % 2 == 0) begin
               line = line % 16;
            end
            issue_read(line);
         end
         wait_idle();
      end

      // disjoint bytes of one line back to back
      for (int r = 0; r < 4; r++) begin
         seed = lcg_step(seed);
         line = int'(seed[13:8]);
         for (int k = 0; k < BE_W; k++) begin
            seed = lcg_step(seed);
            write_word({LINE_ADDR_W'(line), 2'b00}, BE_W'(1) << k, seed);
         end
         for (int w = 1; w < LINE_WORDS; w++) begin
            seed = lcg_step(seed);
            write_word({LINE_ADDR_W'(line), LINE_WORDS_W'(w)}, 4'hf, seed);
         end
         wait_idle();
         issue_read(line);
         issue_read(line);
         wait_idle();
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
rtl/gmem_pkg.sv
rtl/cu_intake.sv
rtl/receiver_pool.sv
rtl/write_merge.sv
rtl/port_arbiter.sv
rtl/line_ram.sv
rtl/gmem_ctrl.sv
testbench/gmem_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# build and run the gmem_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module gmem_ctrl_tb -f list.f -o sim_gmem_ctrl
./obj_dir/sim_gmem_ctrl
